//--- include/rob_commit_defines.svh
////////////////////
// rob_commit global sizes
// data width, register index width and reorder-buffer depth
////////////////////

`ifndef ROB_COMMIT_DEFINES_SVH
`define ROB_COMMIT_DEFINES_SVH

`define XLEN      32 // data and pc width
`define REG_IDX_W 5  // architectural register index
`define ROB_SIZE  8  // reorder-buffer entries, power of two

`endif

//--- verilog/rob_commit_pkg.sv
////////////////////
// rob_commit shared types
// words, indices, tags and commit status codes
////////////////////

`default_nettype none

`include "rob_commit_defines.svh"

package rob_commit_pkg;

    typedef logic [`XLEN-1:0]      xlen_t;    // data or pc word
    typedef logic [`REG_IDX_W-1:0] reg_idx_t; // architectural register

    typedef logic [$clog2(`ROB_SIZE)-1:0]   rob_tag_t;   // rob slot index
    typedef logic [$clog2(`ROB_SIZE+1)-1:0] rob_count_t; // 0 .. ROB_SIZE

    // commit status, held once an error retires
    typedef enum logic [1:0] {
        NO_ERROR      = 2'd0,
        ILLEGAL_INST  = 2'd1,
        HALTED_ON_WFI = 2'd2
    } exception_code_e;

endpackage

`default_nettype wire

//--- verilog/dispatch_stage.sv
////////////////////
// dispatch stage
// hands out rob tags and registers the accepted instruction
// free space check covers the in-flight slot
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_commit_defines.svh"

module dispatch_stage import rob_commit_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    // decoded instruction, plain levels
    input  logic       dispatch_valid,
    input  reg_idx_t   dispatch_reg_idx,
    input  xlen_t      dispatch_npc,
    input  logic       dispatch_halt,
    input  logic       dispatch_illegal,
    // rob status
    input  rob_count_t occupancy,
    input  logic       retire_valid,
    // back to the source
    output logic       rob_available,
    output rob_tag_t   dispatch_tag,
    // allocation into the rob, one cycle after accept
    output logic       alloc_valid,
    output rob_tag_t   alloc_tag,
    output reg_idx_t   alloc_reg_idx,
    output xlen_t      alloc_npc,
    output logic       alloc_done,
    output logic       alloc_halt,
    output logic       alloc_illegal
);

    logic                          accept;
    logic [$bits(rob_count_t):0]   pending; // one extra bit, no wrap

    // entries held plus the one in flight, minus what leaves this edge
    assign pending       = {1'b0, occupancy} + alloc_valid - retire_valid;
    assign rob_available = (pending < `ROB_SIZE);
    assign accept        = dispatch_valid && rob_available;

    ////////////////////
    // tail tag and dispatch register valid
    ////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dispatch_tag <= '0;
            alloc_valid  <= 1'b0;
        end else begin
            alloc_valid <= accept;
            if (accept)
                dispatch_tag <= dispatch_tag + 1'b1; // wraps mod ROB_SIZE
        end
    end

    // payload, only meaningful under alloc_valid
    always_ff @(posedge clock) begin
        if (accept) begin
            alloc_tag     <= dispatch_tag;
            alloc_reg_idx <= dispatch_reg_idx;
            alloc_npc     <= dispatch_npc;
            alloc_done    <= dispatch_halt | dispatch_illegal; // nothing to execute
            alloc_halt    <= dispatch_halt;
            alloc_illegal <= dispatch_illegal;
        end
    end

    // a full rob must freeze the tag sequence
    a_tag_hold_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        !rob_available |=> dispatch_tag == $past(dispatch_tag));

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
////////////////////
// reorder buffer
// circular store, allocate at tail, complete by tag,
// retire in order from head
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_commit_defines.svh"

module reorder_buffer import rob_commit_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    // allocation from dispatch
    input  logic       alloc_valid,
    input  rob_tag_t   alloc_tag,
    input  reg_idx_t   alloc_reg_idx,
    input  xlen_t      alloc_npc,
    input  logic       alloc_done,
    input  logic       alloc_halt,
    input  logic       alloc_illegal,
    // completion broadcast
    input  logic       cdb_valid,
    input  rob_tag_t   cdb_tag,
    input  xlen_t      cdb_value,
    // commit side
    input  logic       commit_stop,
    output rob_count_t occupancy,
    output logic       retire_valid,
    output reg_idx_t   retire_reg_idx,
    output xlen_t      retire_value,
    output xlen_t      retire_npc,
    output logic       retire_halt,
    output logic       retire_illegal
);

    ////////////////////
    // entry storage
    ////////////////////
    logic [`ROB_SIZE-1:0] entry_valid; // slot holds an instruction
    logic [`ROB_SIZE-1:0] entry_done;  // result present

    reg_idx_t entry_reg_idx [`ROB_SIZE];
    xlen_t    entry_value   [`ROB_SIZE];
    xlen_t    entry_npc     [`ROB_SIZE];
    logic     entry_halt    [`ROB_SIZE];
    logic     entry_illegal [`ROB_SIZE];

    rob_tag_t head; // oldest instruction

    ////////////////////
    // retire port driven straight off the head slot
    ////////////////////
    assign retire_valid   = entry_valid[head] && entry_done[head] && !commit_stop;
    assign retire_reg_idx = entry_reg_idx[head];
    assign retire_value   = entry_value[head];
    assign retire_npc     = entry_npc[head];
    assign retire_halt    = entry_halt[head];
    assign retire_illegal = entry_illegal[head];

    // control bits plus head and count
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
            entry_done  <= '0;
            head        <= '0;
            occupancy   <= '0;
        end else begin
            if (retire_valid) begin // release head
                entry_valid[head] <= 1'b0;
                entry_done[head]  <= 1'b0;
                head              <= head + 1'b1;
            end
            if (alloc_valid) begin
                entry_valid[alloc_tag] <= 1'b1;
                entry_done[alloc_tag]  <= alloc_done; // halt/illegal finish here
            end
            if (cdb_valid)
                entry_done[cdb_tag] <= 1'b1;
            occupancy <= occupancy + rob_count_t'(alloc_valid) - rob_count_t'(retire_valid);
        end
    end

    // payload storage
    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            entry_reg_idx[alloc_tag] <= alloc_reg_idx;
            entry_value[alloc_tag]   <= '0; // halt/illegal carry no result
            entry_npc[alloc_tag]     <= alloc_npc;
            entry_halt[alloc_tag]    <= alloc_halt;
            entry_illegal[alloc_tag] <= alloc_illegal;
        end
        if (cdb_valid)
            entry_value[cdb_tag] <= cdb_value;
    end

    ////////////////////
    // checks
    ////////////////////

    // broadcast must hit a live, unfinished slot
    a_cdb_target_live: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> entry_valid[cdb_tag] && !entry_done[cdb_tag]);

    // dispatch tail stays in step with head + count
    a_alloc_at_tail: assert property (@(posedge clock) disable iff (!rst_n)
        alloc_valid |-> alloc_tag == rob_tag_t'(head + rob_tag_t'(occupancy)));

    a_occupancy_bound: assert property (@(posedge clock) disable iff (!rst_n)
        occupancy <= `ROB_SIZE);

endmodule

`default_nettype wire

//--- verilog/commit_stage.sv
////////////////////
// commit stage
// registers each retirement onto the commit outputs,
// stops for good after halt or illegal
////////////////////

`timescale 1ns/100ps
`default_nettype none

module commit_stage import rob_commit_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    // head of the rob
    input  logic            retire_valid,
    input  reg_idx_t        retire_reg_idx,
    input  xlen_t           retire_value,
    input  xlen_t           retire_npc,
    input  logic            retire_halt,
    input  logic            retire_illegal,
    // back to the rob
    output logic            commit_stop,
    // architectural commit port
    output logic [3:0]      completed_insts,
    output exception_code_e error_status,
    output logic            commit_wr_en,
    output reg_idx_t        commit_wr_idx,
    output xlen_t           commit_wr_data,
    output xlen_t           commit_npc
);

    logic stop_event; // halt or illegal leaving the rob now

    assign stop_event = retire_valid && (retire_halt || retire_illegal);

    ////////////////////
    // commit registers
    ////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            commit_stop     <= 1'b0;
            completed_insts <= 4'd0;
            error_status    <= NO_ERROR;
            commit_wr_en    <= 1'b0;
            commit_wr_idx   <= '0;
            commit_wr_data  <= '0;
            commit_npc      <= '0;
        end else begin
            completed_insts <= {3'b0, retire_valid}; // at most one per cycle
            commit_wr_en    <= retire_valid && (retire_reg_idx != '0); // r0 never written
            if (retire_valid) begin
                commit_wr_idx  <= retire_reg_idx;
                commit_wr_data <= retire_value;
                commit_npc     <= retire_npc;
            end
            // sticky status, illegal wins over halt
            if (retire_valid && retire_illegal)
                error_status <= ILLEGAL_INST;
            else if (retire_valid && retire_halt)
                error_status <= HALTED_ON_WFI;
            if (stop_event)
                commit_stop <= 1'b1; // cleared only by reset
        end
    end

    // rob must honour the stop from the next cycle on
    a_no_retire_after_stop: assert property (@(posedge clock) disable iff (!rst_n)
        commit_stop |-> !retire_valid);

endmodule

`default_nettype wire

//--- verilog/rob_commit.sv
////////////////////
// rob_commit top
// dispatch, reorder buffer and commit in a row
////////////////////

`timescale 1ns/100ps
`default_nettype none

module rob_commit import rob_commit_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    // decoded instruction in
    input  logic            dispatch_valid,
    input  reg_idx_t        dispatch_reg_idx,
    input  xlen_t           dispatch_npc,
    input  logic            dispatch_halt,
    input  logic            dispatch_illegal,
    // completion broadcast
    input  logic            cdb_valid,
    input  rob_tag_t        cdb_tag,
    input  xlen_t           cdb_value,
    // dispatch feedback
    output logic            rob_available,
    output rob_tag_t        dispatch_tag,
    // commit port
    output logic [3:0]      completed_insts,
    output exception_code_e error_status,
    output logic            commit_wr_en,
    output reg_idx_t        commit_wr_idx,
    output xlen_t           commit_wr_data,
    output xlen_t           commit_npc
);

    ////////////////////
    // stage wires
    ////////////////////
    logic       alloc_valid;
    rob_tag_t   alloc_tag;
    reg_idx_t   alloc_reg_idx;
    xlen_t      alloc_npc;
    logic       alloc_done;
    logic       alloc_halt;
    logic       alloc_illegal;

    rob_count_t occupancy;
    logic       retire_valid;
    reg_idx_t   retire_reg_idx;
    xlen_t      retire_value;
    xlen_t      retire_npc;
    logic       retire_halt;
    logic       retire_illegal;
    logic       commit_stop;

    dispatch_stage u_dispatch_stage (
        .clock            (clock),
        .rst_n            (rst_n),
        .dispatch_valid   (dispatch_valid),
        .dispatch_reg_idx (dispatch_reg_idx),
        .dispatch_npc     (dispatch_npc),
        .dispatch_halt    (dispatch_halt),
        .dispatch_illegal (dispatch_illegal),
        .occupancy        (occupancy),
        .retire_valid     (retire_valid),
        .rob_available    (rob_available),
        .dispatch_tag     (dispatch_tag),
        .alloc_valid      (alloc_valid),
        .alloc_tag        (alloc_tag),
        .alloc_reg_idx    (alloc_reg_idx),
        .alloc_npc        (alloc_npc),
        .alloc_done       (alloc_done),
        .alloc_halt       (alloc_halt),
        .alloc_illegal    (alloc_illegal)
    );

    reorder_buffer u_reorder_buffer (
        .clock          (clock),
        .rst_n          (rst_n),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag),
        .alloc_reg_idx  (alloc_reg_idx),
        .alloc_npc      (alloc_npc),
        .alloc_done     (alloc_done),
        .alloc_halt     (alloc_halt),
        .alloc_illegal  (alloc_illegal),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .commit_stop    (commit_stop),
        .occupancy      (occupancy),
        .retire_valid   (retire_valid),
        .retire_reg_idx (retire_reg_idx),
        .retire_value   (retire_value),
        .retire_npc     (retire_npc),
        .retire_halt    (retire_halt),
        .retire_illegal (retire_illegal)
    );

    commit_stage u_commit_stage (
        .clock           (clock),
        .rst_n           (rst_n),
        .retire_valid    (retire_valid),
        .retire_reg_idx  (retire_reg_idx),
        .retire_value    (retire_value),
        .retire_npc      (retire_npc),
        .retire_halt     (retire_halt),
        .retire_illegal  (retire_illegal),
        .commit_stop     (commit_stop),
        .completed_insts (completed_insts),
        .error_status    (error_status),
        .commit_wr_en    (commit_wr_en),
        .commit_wr_idx   (commit_wr_idx),
        .commit_wr_data  (commit_wr_data),
        .commit_npc      (commit_npc)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
////////////////////
// testbench clock and reset
// 4 ns clock, reset low for three cycles,
// again on every restart pulse
////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    input  logic restart, // rising edge starts a fresh reset
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock; // 250 MHz
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        #1 rst_n = 1'b1;
        forever begin
            @(posedge restart);
            rst_n = 1'b0; // async assert
            repeat (3) @(posedge clock);
            #1 rst_n = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_rob_commit.sv
////////////////////
// rob_commit testbench
// table driven dispatch, shuffled completions,
// in-order commit monitor, stop after illegal / halt
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_commit_defines.svh"

module tb_rob_commit
    import rob_commit_pkg::*;
();

    localparam int NUM_ROWS   = 26;
    localparam int WAIT_LIMIT = 300; // cycles per wait loop

    logic clock;
    logic rst_n;
    logic restart = 1'b0;

    // dut inputs
    logic     dispatch_valid;
    reg_idx_t dispatch_reg_idx;
    xlen_t    dispatch_npc;
    logic     dispatch_halt;
    logic     dispatch_illegal;
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    xlen_t    cdb_value;

    // dut outputs
    logic            rob_available;
    rob_tag_t        dispatch_tag;
    logic [3:0]      completed_insts;
    exception_code_e error_status;
    logic            commit_wr_en;
    reg_idx_t        commit_wr_idx;
    xlen_t           commit_wr_data;
    xlen_t           commit_npc;

    ////////////////////
    // stimulus table
    ////////////////////
    reg_idx_t row_idx     [NUM_ROWS];
    xlen_t    row_npc     [NUM_ROWS];
    xlen_t    row_value   [NUM_ROWS];
    logic     row_halt    [NUM_ROWS];
    logic     row_illegal [NUM_ROWS];
    int       row_delay   [NUM_ROWS]; // cycles before the strobe may go out

    int exp_q[$];       // rows expected to commit in order
    int cmp_row_q[$];   // rows still waiting for a completion
    int cmp_tag_q[$];
    int cmp_ready_q[$]; // earliest cycle for the strobe

    int   cycle = 0;
    int   accept_count;
    logic seg_stopped;    // halt or illegal already dispatched
    logic completions_on;

    tb_clock_gen u_clock_gen (
        .restart (restart),
        .clock   (clock),
        .rst_n   (rst_n)
    );

    rob_commit i_rob_commit (
        .clock            (clock),
        .rst_n            (rst_n),
        .dispatch_valid   (dispatch_valid),
        .dispatch_reg_idx (dispatch_reg_idx),
        .dispatch_npc     (dispatch_npc),
        .dispatch_halt    (dispatch_halt),
        .dispatch_illegal (dispatch_illegal),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        .rob_available    (rob_available),
        .dispatch_tag     (dispatch_tag),
        .completed_insts  (completed_insts),
        .error_status     (error_status),
        .commit_wr_en     (commit_wr_en),
        .commit_wr_idx    (commit_wr_idx),
        .commit_wr_data   (commit_wr_data),
        .commit_npc       (commit_npc)
    );

    always @(posedge clock) cycle <= cycle + 1;

    ////////////////////
    // error handling and compares
    ////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_tag(input string name, input rob_tag_t exp, input rob_tag_t act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_status(input string name, input exception_code_e exp,
                                input exception_code_e act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %s, actual %s",
                                    name, exp.name(), act.name()));
    endtask

    task automatic check_count(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    endtask

    function automatic exception_code_e expected_status(input int r);
        if (row_illegal[r])
            return ILLEGAL_INST;
        if (row_halt[r])
            return HALTED_ON_WFI;
        return NO_ERROR;
    endfunction

    ////////////////////
    // table and drivers
    ////////////////////
    task automatic add_row(input int r, input reg_idx_t idx, input xlen_t npc,
                           input xlen_t value, input logic halt, input logic illegal,
                           input int delay);
        row_idx[r]     = idx;
        row_npc[r]     = npc;
        row_value[r]   = value;
        row_halt[r]    = halt;
        row_illegal[r] = illegal;
        row_delay[r]   = delay;
    endtask

    task automatic build_table();
        int r;
        for (r = 0; r < 20; r++) // plain rows where row 5 targets r0
            add_row(r, (r == 5) ? reg_idx_t'(0) : reg_idx_t'((r * 7 + 3) % 32),
                    xlen_t'(32'h0000_1000 + 4 * (r + 1)), $urandom, 1'b0, 1'b0,
                    $urandom_range(0, 6));
        add_row(20, 5'd0,  32'h0000_2000, 32'h0000_0000, 1'b0, 1'b1, 0); // illegal
        add_row(21, 5'd10, 32'h0000_2004, 32'h1515_2121, 1'b0, 1'b0, 1); // stuck behind it
        add_row(22, 5'd11, 32'h0000_2008, 32'h2222_3333, 1'b0, 1'b0, 0);
        add_row(23, 5'd1,  32'h0000_3004, 32'h0a0b_0c0d, 1'b0, 1'b0, 2); // second segment
        add_row(24, 5'd0,  32'h0000_3008, 32'h0000_0000, 1'b1, 1'b0, 0); // halt
        add_row(25, 5'd2,  32'h0000_300c, 32'h3c3c_4d4d, 1'b0, 1'b0, 0);
    endtask

    task automatic drive_row(input int r);
        dispatch_valid   = 1'b1;
        dispatch_reg_idx = row_idx[r];
        dispatch_npc     = row_npc[r];
        dispatch_halt    = row_halt[r];
        dispatch_illegal = row_illegal[r];
    endtask

    // hold the row until rob_available then take one accept edge
    task automatic dispatch_row(input int r);
        int waited;
        waited = 0;
        drive_row(r);
        while (!rob_available) begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_error($sformatf("timeout: row %0d was never accepted", r));
        end
        check_tag($sformatf("row %0d dispatch_tag", r),
                  rob_tag_t'(accept_count % `ROB_SIZE), dispatch_tag);
        if (row_halt[r] == 1'b0 && row_illegal[r] == 1'b0) begin
            cmp_row_q.push_back(r);
            cmp_tag_q.push_back(int'(dispatch_tag));
            cmp_ready_q.push_back(cycle + 2 + row_delay[r]); // entry lands two edges on
        end
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
        accept_count++;
        if (!seg_stopped)
            exp_q.push_back(r); // rows behind a stop never commit
        if (row_halt[r] || row_illegal[r])
            seg_stopped = 1'b1;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clock);
            waited++;
            if (waited > 10)
                stop_on_error("timeout: reset was never released");
        end
        @(posedge clock);
        #1;
    endtask

    task automatic check_reset_state();
        check_bit("reset rob_available", 1'b1, rob_available);
        check_tag("reset dispatch_tag", '0, dispatch_tag);
        check_count("reset completed_insts", 4'd0, completed_insts);
        check_bit("reset commit_wr_en", 1'b0, commit_wr_en);
        check_status("reset error_status", NO_ERROR, error_status);
        check_reg_idx("reset commit_wr_idx", '0, commit_wr_idx);
        check_xlen("reset commit_wr_data", '0, commit_wr_data);
        check_xlen("reset commit_npc", '0, commit_npc);
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || cmp_row_q.size() != 0) begin
            @(posedge clock);
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_error("timeout: expected commits did not all arrive");
        end
    endtask

    // completed rows wait behind the stop and nothing may retire
    task automatic quiet_window(input exception_code_e held);
        int n;
        for (n = 0; n < 20; n++) begin
            @(negedge clock);
            check_count("quiet completed_insts", 4'd0, completed_insts);
            check_status("held error_status", held, error_status);
        end
    endtask

    ////////////////////
    // completion strobes on a random pick of eligible tags
    ////////////////////
    initial begin : completion_driver
        int ready[$];
        int pick;
        forever begin
            @(posedge clock);
            #1;
            cdb_valid = 1'b0;
            if (completions_on && rst_n) begin
                ready.delete();
                foreach (cmp_row_q[k])
                    if (cycle >= cmp_ready_q[k])
                        ready.push_back(k);
                if (ready.size() > 0) begin
                    pick      = ready[$urandom_range(0, ready.size() - 1)];
                    cdb_valid = 1'b1;
                    cdb_tag   = rob_tag_t'(cmp_tag_q[pick]);
                    cdb_value = row_value[cmp_row_q[pick]];
                    cmp_row_q.delete(pick);
                    cmp_tag_q.delete(pick);
                    cmp_ready_q.delete(pick);
                end
            end
        end
    end

    // commit monitor sampled mid cycle
    initial begin : commit_monitor
        int r;
        forever begin
            @(negedge clock);
            if (completed_insts != 4'd0) begin
                if (exp_q.size() == 0)
                    stop_on_error("unexpected commit with no instruction left to retire");
                r = exp_q.pop_front();
                check_count($sformatf("row %0d completed_insts", r), 4'd1, completed_insts);
                check_bit($sformatf("row %0d commit_wr_en", r), row_idx[r] != '0, commit_wr_en);
                check_reg_idx($sformatf("row %0d commit_wr_idx", r), row_idx[r], commit_wr_idx);
                if (!row_halt[r] && !row_illegal[r])
                    check_xlen($sformatf("row %0d commit_wr_data", r), row_value[r],
                               commit_wr_data);
                check_xlen($sformatf("row %0d commit_npc", r), row_npc[r], commit_npc);
                check_status($sformatf("row %0d error_status", r), expected_status(r),
                             error_status);
            end else begin
                check_bit("idle commit_wr_en", 1'b0, commit_wr_en);
            end
        end
    end

    ////////////////////
    // main sequence
    ////////////////////
    initial begin : main_sequence
        int r;
        dispatch_valid   = 1'b0;
        dispatch_reg_idx = '0;
        dispatch_npc     = '0;
        dispatch_halt    = 1'b0;
        dispatch_illegal = 1'b0;
        cdb_valid        = 1'b0;
        cdb_tag          = '0;
        cdb_value        = '0;
        completions_on   = 1'b0;
        seg_stopped      = 1'b0;
        accept_count     = 0;
        void'($urandom(32'hf4567c44));
        build_table();

        wait_reset_release();
        check_reset_state();

        // fill the rob with nothing completed
        for (r = 0; r < `ROB_SIZE; r++)
            dispatch_row(r);
        drive_row(`ROB_SIZE); // held at the source
        repeat (6) begin
            check_bit("full rob_available", 1'b0, rob_available);
            check_tag("full dispatch_tag", rob_tag_t'(`ROB_SIZE % `ROB_SIZE), dispatch_tag);
            @(posedge clock);
            #1;
        end
        completions_on = 1'b1;
        for (r = `ROB_SIZE; r <= 22; r++)
            dispatch_row(r); // tags wrap and row 20 is illegal
        wait_for_drain();
        quiet_window(ILLEGAL_INST);

        // second segment ends in a halt
        restart = 1'b1;
        @(posedge clock);
        #1;
        restart = 1'b0;
        wait_reset_release();
        check_reset_state();
        accept_count = 0;
        seg_stopped  = 1'b0;
        for (r = 23; r <= 25; r++)
            dispatch_row(r);
        wait_for_drain();
        quiet_window(HALTED_ON_WFI);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rob_commit.f
+incdir+include
verilog/rob_commit_pkg.sv
verilog/dispatch_stage.sv
verilog/reorder_buffer.sv
verilog/commit_stage.sv
verilog/rob_commit.sv
tb/tb_clock_gen.sv
tb/tb_rob_commit.sv

//--- run_sim.sh
#!/bin/sh
# build the rob_commit testbench with Verilator and run it
# exit status is nonzero when the build fails or the testbench stops on $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    -f rob_commit.f --top-module tb_rob_commit -o tb_rob_commit_sim \
    && ./obj_dir/tb_rob_commit_sim \
    || exit 1
